//--- Makefile
# Verilator build and run for the multiply/divide writeback testbench.

VERILATOR ?= verilator
TOP       ?= muldiv_wb_tb
FILELIST  ?= muldiv_wb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a result line"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/div_iter.sv
// iterative radix-2 restoring divider for DIVU and REMU.
// one quotient bit per cycle, result buffered in its own FIFO.

`timescale 1ns/1ps

module div_iter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  muldiv_pkg::muldiv_op_t issue_op,
    input  muldiv_pkg::xlen_t      issue_rs1,
    input  muldiv_pkg::xlen_t      issue_rs2,
    input  muldiv_pkg::id_t        issue_id,
    output logic                   div_ready,
    output logic                   res_valid,
    output muldiv_pkg::wb_entry_t  res_entry,
    input  logic                   res_pop
);

    muldiv_pkg::div_state_t                 state;
    logic [muldiv_pkg::DIV_CNT_WIDTH-1:0]   step_cnt;
    logic                                   is_div_op;
    logic                                   accept;
    logic                                   fifo_full;

    // working registers.
    logic                                   is_rem;
    muldiv_pkg::id_t                        op_id;
    muldiv_pkg::xlen_t                      divisor;
    muldiv_pkg::xlen_t                      quot;
    muldiv_pkg::xlen_t                      rem;

    // one restoring step.
    logic [muldiv_pkg::XLEN:0]              shifted;
    logic [muldiv_pkg::XLEN:0]              diff;
    logic                                   take;

    logic                                   push;
    muldiv_pkg::wb_entry_t                  push_entry;

    assign is_div_op = (issue_op == muldiv_pkg::DIVU) || (issue_op == muldiv_pkg::REMU);
    assign accept    = issue && is_div_op && div_ready;

    // a free slot at issue stays free until DONE.
    assign div_ready = (state == muldiv_pkg::IDLE) && !fifo_full;

    // bring in the next dividend bit and trial subtract.
    assign shifted = {rem, quot[muldiv_pkg::XLEN-1]};
    assign diff    = shifted - {1'b0, divisor};
    assign take    = ~diff[muldiv_pkg::XLEN];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= muldiv_pkg::IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                muldiv_pkg::IDLE: begin
                    step_cnt <= '0;
                    if (accept) begin
                        state <= muldiv_pkg::RUN;
                    end
                end
                muldiv_pkg::RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == muldiv_pkg::DIV_CNT_WIDTH'(muldiv_pkg::DIV_CYCLES - 1)) begin
                        state <= muldiv_pkg::DONE;
                    end
                end
                muldiv_pkg::DONE: begin
                    state <= muldiv_pkg::IDLE;
                end
                default: begin
                    state <= muldiv_pkg::IDLE;
                end
            endcase
        end
    end

    // datapath.
    // a zero divisor always subtracts, giving all ones and the dividend.
    always_ff @(posedge clk) begin
        if (state == muldiv_pkg::IDLE && accept) begin
            is_rem  <= (issue_op == muldiv_pkg::REMU);
            op_id   <= issue_id;
            divisor <= issue_rs2;
            quot    <= issue_rs1;
            rem     <= '0;
        end else if (state == muldiv_pkg::RUN) begin
            quot <= {quot[muldiv_pkg::XLEN-2:0], take};
            rem  <= take ? diff[muldiv_pkg::XLEN-1:0] : shifted[muldiv_pkg::XLEN-1:0];
        end
    end

    assign push       = (state == muldiv_pkg::DONE);
    assign push_entry = {op_id, (is_rem ? rem : quot)};

    lutram_fifo #(
        .DATA_WIDTH ($bits(muldiv_pkg::wb_entry_t)),
        .FIFO_DEPTH (muldiv_pkg::DIV_FIFO_DEPTH)
    ) i_div_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (push),
        .pop         (res_pop),
        .data_in     (push_entry),
        .data_out    (res_entry),
        .valid       (res_valid),
        .early_valid (),
        .full        (fifo_full),
        .early_full  ()
    );

    // caller must wait for div_ready before a divide.
    a_issue_ready: assert property (@(posedge clk) disable iff (rst)
        (issue && is_div_op) |-> div_ready);

    // an accepted divide pushes its result after the full iteration count.
    a_push_latency: assert property (@(posedge clk) disable iff (rst)
        accept |-> ##(muldiv_pkg::DIV_CYCLES + 1) push);

endmodule

//--- design/lutram_fifo.sv
// small LUT RAM FIFO for result buffering.
// one-hot occupancy vector gives cheap full/valid flags.

`timescale 1ns/1ps

module lutram_fifo #(
    parameter int DATA_WIDTH = 35,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic                  pop,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid,
    output logic                  early_valid,
    output logic                  full,
    output logic                  early_full
);

    // storage, no reset needed.
    logic [DATA_WIDTH-1:0] lut_ram [FIFO_DEPTH];

    // indices wrap naturally for power of two depths.
    logic [$clog2(FIFO_DEPTH)-1:0] write_index;
    logic [$clog2(FIFO_DEPTH)-1:0] read_index;

    // bit n set means n entries held.
    logic [FIFO_DEPTH:0] count_v;

    // head of queue read asynchronously.
    assign data_out = lut_ram[read_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            read_index  <= '0;
            write_index <= '0;
        end else begin
            read_index  <= read_index + pop;
            write_index <= write_index + push;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            lut_ram[write_index] <= data_in;
        end
    end

    // shift up on push only, down on pop only.
    always_ff @(posedge clk) begin
        if (rst) begin
            count_v <= (FIFO_DEPTH+1)'(1);
        end else if (push && !pop) begin
            count_v <= {count_v[FIFO_DEPTH-1:0], 1'b0};
        end else if (!push && pop) begin
            count_v <= {1'b0, count_v[FIFO_DEPTH:1]};
        end
    end

    assign full  = count_v[FIFO_DEPTH];
    assign valid = ~count_v[0];

    // one slot left or none, full may be reached next cycle.
    assign early_full = count_v[FIFO_DEPTH-1] | count_v[FIFO_DEPTH];

    // a push, two or more held, or one held and kept.
    assign early_valid = push | (~count_v[0] & ~count_v[1]) | (~count_v[0] & ~pop);

    // the producing unit must hold off when its FIFO is full.
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);

    // the arbiter must only pop a FIFO that holds an entry.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> valid);

endmodule

//--- design/mul_pipe.sv
// pipelined unsigned multiplier for MUL and MULHU.
// operand register, registered product half, then result FIFO write.

`timescale 1ns/1ps

module mul_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  muldiv_pkg::muldiv_op_t issue_op,
    input  muldiv_pkg::xlen_t      issue_rs1,
    input  muldiv_pkg::xlen_t      issue_rs2,
    input  muldiv_pkg::id_t        issue_id,
    output logic                   mul_ready,
    output logic                   res_valid,
    output muldiv_pkg::wb_entry_t  res_entry,
    input  logic                   res_pop
);

    logic                                      is_mul_op;
    logic                                      accept;
    logic [muldiv_pkg::MUL_CREDIT_WIDTH-1:0]   credits;

    // stage one registers.
    logic                                      s1_valid;
    logic                                      s1_high;
    muldiv_pkg::xlen_t                         s1_rs1;
    muldiv_pkg::xlen_t                         s1_rs2;
    muldiv_pkg::id_t                           s1_id;

    logic [2*muldiv_pkg::XLEN-1:0]             product;
    muldiv_pkg::xlen_t                         result;
    muldiv_pkg::wb_entry_t                     push_entry;

    // stage two registers.
    logic                                      s2_valid;
    muldiv_pkg::wb_entry_t                     s2_entry;

    assign is_mul_op = (issue_op == muldiv_pkg::MUL) || (issue_op == muldiv_pkg::MULHU);
    assign accept    = issue && is_mul_op && mul_ready;

    // credits cover the FIFO plus whatever is in the pipe.
    // taken on issue, returned on pop.
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= '0;
        end else if (accept && !res_pop) begin
            credits <= credits + 1'b1;
        end else if (!accept && res_pop) begin
            credits <= credits - 1'b1;
        end
    end

    assign mul_ready = (credits < muldiv_pkg::MUL_FIFO_DEPTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
        end
    end

    // operands and tag.
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_high <= (issue_op == muldiv_pkg::MULHU);
            s1_rs1  <= issue_rs1;
            s1_rs2  <= issue_rs2;
            s1_id   <= issue_id;
        end
    end

    // full width unsigned product.
    assign product = s1_rs1 * s1_rs2;

    // low or high half with its tag.
    assign result     = s1_high ? product[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN]
                                : product[muldiv_pkg::XLEN-1:0];
    assign push_entry = {s1_id, result};

    // stage two holds the selected half until the FIFO write.
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_entry <= push_entry;
        end
    end

    lutram_fifo #(
        .DATA_WIDTH ($bits(muldiv_pkg::wb_entry_t)),
        .FIFO_DEPTH (muldiv_pkg::MUL_FIFO_DEPTH)
    ) i_mul_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (s2_valid),
        .pop         (res_pop),
        .data_in     (s2_entry),
        .data_out    (res_entry),
        .valid       (res_valid),
        .early_valid (),
        .full        (),
        .early_full  ()
    );

    // caller must wait for mul_ready before a multiply.
    a_issue_ready: assert property (@(posedge clk) disable iff (rst)
        (issue && is_mul_op) |-> mul_ready);

endmodule

//--- design/muldiv_pkg.sv
// multiply/divide writeback package.
// shared widths, operation and state encodings, and FIFO sizing.

package muldiv_pkg;

    // operand and result width.
    localparam int XLEN = 32;

    // instruction tag width, eight tags in flight.
    localparam int ID_WIDTH = 3;

    // a FIFO entry holds the tag above the data.
    localparam int WB_ENTRY_WIDTH = ID_WIDTH + XLEN;

    // result FIFO depths per unit.
    localparam int MUL_FIFO_DEPTH = 4;
    localparam int DIV_FIFO_DEPTH = 2;

    // one quotient bit per iteration.
    localparam int DIV_CYCLES = 32;

    // iteration counter width.
    localparam int DIV_CNT_WIDTH = $clog2(DIV_CYCLES);

    // credit counter must reach MUL_FIFO_DEPTH itself.
    localparam int MUL_CREDIT_WIDTH = $clog2(MUL_FIFO_DEPTH + 1);

    // operand or result word.
    typedef logic [XLEN-1:0] xlen_t;

    // instruction tag.
    typedef logic [ID_WIDTH-1:0] id_t;

    // tag and data packed as {id, data}.
    typedef logic [WB_ENTRY_WIDTH-1:0] wb_entry_t;

    // unsigned operations only.
    typedef enum logic [1:0] {
        MUL   = 2'd0,
        MULHU = 2'd1,
        DIVU  = 2'd2,
        REMU  = 2'd3
    } muldiv_op_t;

    // divider control states.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } div_state_t;

endpackage

//--- design/muldiv_wb.sv
// multiply/divide writeback top level.
// multiplier and divider side by side, merged by the writeback arbiter.

`timescale 1ns/1ps

module muldiv_wb (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  muldiv_pkg::muldiv_op_t issue_op,
    input  muldiv_pkg::xlen_t      issue_rs1,
    input  muldiv_pkg::xlen_t      issue_rs2,
    input  muldiv_pkg::id_t        issue_id,
    output logic                   mul_ready,
    output logic                   div_ready,
    output logic                   wb_valid,
    output muldiv_pkg::id_t        wb_id,
    output muldiv_pkg::xlen_t      wb_data
);

    // multiplier FIFO head.
    logic                  mul_valid;
    muldiv_pkg::wb_entry_t mul_entry;
    logic                  mul_pop;

    // divider FIFO head.
    logic                  div_valid;
    muldiv_pkg::wb_entry_t div_entry;
    logic                  div_pop;

    mul_pipe i_mul_pipe (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .issue_op  (issue_op),
        .issue_rs1 (issue_rs1),
        .issue_rs2 (issue_rs2),
        .issue_id  (issue_id),
        .mul_ready (mul_ready),
        .res_valid (mul_valid),
        .res_entry (mul_entry),
        .res_pop   (mul_pop)
    );

    div_iter i_div_iter (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .issue_op  (issue_op),
        .issue_rs1 (issue_rs1),
        .issue_rs2 (issue_rs2),
        .issue_id  (issue_id),
        .div_ready (div_ready),
        .res_valid (div_valid),
        .res_entry (div_entry),
        .res_pop   (div_pop)
    );

    wb_arbiter i_wb_arbiter (
        .clk       (clk),
        .rst       (rst),
        .mul_valid (mul_valid),
        .mul_entry (mul_entry),
        .mul_pop   (mul_pop),
        .div_valid (div_valid),
        .div_entry (div_entry),
        .div_pop   (div_pop),
        .wb_valid  (wb_valid),
        .wb_id     (wb_id),
        .wb_data   (wb_data)
    );

endmodule

//--- design/wb_arbiter.sv
// round-robin writeback arbiter over the two result FIFOs.
// one pop per cycle, registered onto the writeback port.

`timescale 1ns/1ps

module wb_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mul_valid,
    input  muldiv_pkg::wb_entry_t mul_entry,
    output logic                  mul_pop,
    input  logic                  div_valid,
    input  muldiv_pkg::wb_entry_t div_entry,
    output logic                  div_pop,
    output logic                  wb_valid,
    output muldiv_pkg::id_t       wb_id,
    output muldiv_pkg::xlen_t     wb_data
);

    // set when the multiplier won the last grant.
    logic                  last_mul;
    muldiv_pkg::wb_entry_t sel_entry;

    // multiplier wins alone, or on a tie when the divider went last.
    assign mul_pop = mul_valid && (!div_valid || !last_mul);
    assign div_pop = div_valid && !mul_pop;

    assign sel_entry = mul_pop ? mul_entry : div_entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mul <= 1'b0;
        end else if (mul_pop) begin
            last_mul <= 1'b1;
        end else if (div_pop) begin
            last_mul <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mul_pop || div_pop;
        end
    end

    // entry split into tag and data.
    always_ff @(posedge clk) begin
        if (mul_pop || div_pop) begin
            wb_id   <= sel_entry[muldiv_pkg::XLEN +: muldiv_pkg::ID_WIDTH];
            wb_data <= sel_entry[muldiv_pkg::XLEN-1:0];
        end
    end

    // a single writeback port, so never two pops at once.
    a_one_pop: assert property (@(posedge clk) disable iff (rst) !(mul_pop && div_pop));

endmodule

//--- dv/muldiv_wb_tb.sv
// directed testbench for the multiply/divide writeback top level.
// reference model and per-id scoreboard check every writeback.

`timescale 1ns/1ps

module muldiv_wb_tb;

    // slack on top of the per-operation cycle budget.
    localparam int TIMEOUT_MARGIN = 200;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   issue;
    muldiv_pkg::muldiv_op_t issue_op;
    muldiv_pkg::xlen_t      issue_rs1;
    muldiv_pkg::xlen_t      issue_rs2;
    muldiv_pkg::id_t        issue_id;
    logic                   mul_ready;
    logic                   div_ready;
    logic                   wb_valid;
    muldiv_pkg::id_t        wb_id;
    muldiv_pkg::xlen_t      wb_data;

    // scoreboard, one slot per tag.
    logic                   pending [8];
    muldiv_pkg::xlen_t      expected_data [8];
    int                     issue_cycle [8];
    int                     wb_latency [8];

    int                     cycle = 0;
    int                     n_issued = 0;
    int                     mismatch_count = 0;
    int                     other_errors = 0;
    int                     ready_low_cycles = 0;
    logic                   watch_ready = 1'b0;
    string                  test_name;

    muldiv_wb i_muldiv_wb (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .issue_op  (issue_op),
        .issue_rs1 (issue_rs1),
        .issue_rs2 (issue_rs2),
        .issue_id  (issue_id),
        .mul_ready (mul_ready),
        .div_ready (div_ready),
        .wb_valid  (wb_valid),
        .wb_id     (wb_id),
        .wb_data   (wb_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // unsigned results as the ISA defines them.
    // divide by zero gives all ones and the dividend.
    function automatic muldiv_pkg::xlen_t model_result(input muldiv_pkg::muldiv_op_t op,
                                                       input muldiv_pkg::xlen_t a,
                                                       input muldiv_pkg::xlen_t b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        case (op)
            muldiv_pkg::MUL:   return prod[31:0];
            muldiv_pkg::MULHU: return prod[63:32];
            muldiv_pkg::DIVU:  return (b == 0) ? 32'hffffffff : a / b;
            default:           return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic logic unit_ready(input muldiv_pkg::muldiv_op_t op);
        if (op == muldiv_pkg::MUL || op == muldiv_pkg::MULHU) begin
            return mul_ready;
        end
        return div_ready;
    endfunction

    function automatic logic any_pending();
        for (int i = 0; i < 8; i++) begin
            if (pending[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // called on a falling edge, returns one falling edge after the strobe.
    // waits for the unit to be ready and the tag to be free.
    task automatic issue_one(input muldiv_pkg::muldiv_op_t op, input muldiv_pkg::xlen_t a,
                             input muldiv_pkg::xlen_t b, input int id);
        while (pending[id] || !unit_ready(op)) begin
            @(negedge clk);
        end
        issue             = 1'b1;
        issue_op          = op;
        issue_rs1         = a;
        issue_rs2         = b;
        issue_id          = muldiv_pkg::id_t'(id);
        expected_data[id] = model_result(op, a, b);
        pending[id]       = 1'b1;
        n_issued++;
        @(negedge clk);
        issue = 1'b0;
        // latency counts from the edge that took the strobe.
        issue_cycle[id] = cycle;
    endtask

    task automatic wait_idle();
        while (any_pending()) begin
            @(negedge clk);
        end
        // a few more edges to catch a late duplicate.
        repeat (4) @(negedge clk);
    endtask

    // writeback monitor, sampled away from the rising edge.
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (!pending[wb_id]) begin
                $display("writeback for id %0d arrived with no operation pending", wb_id);
                other_errors++;
            end else begin
                check_value($sformatf("%s id %0d", test_name, wb_id), expected_data[wb_id],
                            wb_data);
                wb_latency[wb_id] = cycle - issue_cycle[wb_id];
                pending[wb_id]    = 1'b0;
            end
        end
        if (watch_ready && !mul_ready) begin
            ready_low_cycles++;
        end
    end

    task automatic test_reset();
        test_name = "reset";
        check_value("reset mul_ready", 32'd1, 32'(mul_ready));
        check_value("reset div_ready", 32'd1, 32'(div_ready));
        repeat (5) begin
            check_value("reset wb_valid", 32'd0, 32'(wb_valid));
            @(negedge clk);
        end
    endtask

    task automatic test_multiplies();
        test_name = "multiplies";
        // id 0 goes first into an empty pipe.
        issue_one(muldiv_pkg::MUL, 32'd0, 32'd0, 0);
        issue_one(muldiv_pkg::MULHU, 32'hffffffff, 32'hffffffff, 1);
        issue_one(muldiv_pkg::MUL, 32'hffffffff, 32'hffffffff, 2);
        issue_one(muldiv_pkg::MULHU, 32'h80000000, 32'd2, 3);
        issue_one(muldiv_pkg::MULHU, 32'd1, 32'hffffffff, 4);
        for (int i = 5; i < 20; i++) begin
            issue_one((i % 2 == 1) ? muldiv_pkg::MULHU : muldiv_pkg::MUL, $urandom(),
                      $urandom(), 1 + (i % 7));
        end
        wait_idle();
        check_value("multiplies first latency", 32'd3, 32'(wb_latency[0]));
    endtask

    task automatic test_divides();
        int waited;
        test_name = "divides";
        waited    = 0;
        issue_one(muldiv_pkg::DIVU, 32'd100, 32'd7, 0);
        check_value("divides busy", 32'd0, 32'(div_ready));
        // the unit stays closed for the whole iteration.
        while (!div_ready && waited < 4 * muldiv_pkg::DIV_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        check_value("divides refused", 32'd1, 32'(waited >= muldiv_pkg::DIV_CYCLES));
        issue_one(muldiv_pkg::REMU, 32'd100, 32'd7, 1);
        issue_one(muldiv_pkg::DIVU, 32'hdeadbeef, 32'd0, 2);
        issue_one(muldiv_pkg::REMU, 32'hdeadbeef, 32'd0, 3);
        issue_one(muldiv_pkg::DIVU, 32'hcafef00d, 32'd1, 4);
        issue_one(muldiv_pkg::REMU, 32'hcafef00d, 32'd1, 5);
        issue_one(muldiv_pkg::DIVU, $urandom(), $urandom_range(1, 1000), 6);
        issue_one(muldiv_pkg::REMU, $urandom(), $urandom(), 7);
        wait_idle();
    endtask

    task automatic test_mixed();
        muldiv_pkg::muldiv_op_t ops [8];
        test_name = "mixed";
        ops = '{muldiv_pkg::MUL, muldiv_pkg::DIVU, muldiv_pkg::MULHU, muldiv_pkg::MUL,
                muldiv_pkg::REMU, muldiv_pkg::MULHU, muldiv_pkg::DIVU, muldiv_pkg::MUL};
        for (int i = 0; i < 8; i++) begin
            issue_one(ops[i], $urandom(), $urandom(), i);
        end
        wait_idle();
    endtask

    task automatic test_backpressure();
        test_name        = "backpressure";
        ready_low_cycles = 0;
        watch_ready      = 1'b1;
        // divides on tags 6 and 7, multiplies cycle over the rest.
        issue_one(muldiv_pkg::DIVU, $urandom(), $urandom(), 7);
        for (int i = 0; i < 80; i++) begin
            if (i == 36) begin
                issue_one(muldiv_pkg::REMU, $urandom(), $urandom(), 6);
            end
            issue_one(($urandom_range(0, 1) == 0) ? muldiv_pkg::MUL : muldiv_pkg::MULHU,
                      $urandom(), $urandom(), i % 6);
        end
        wait_idle();
        watch_ready = 1'b0;
        $display("backpressure: mul_ready low for %0d cycles", ready_low_cycles);
        check_value("backpressure mul_ready dropped", 32'd1, 32'(ready_low_cycles > 0));
        check_value("backpressure mul_ready", 32'd1, 32'(mul_ready));
        check_value("backpressure div_ready", 32'd1, 32'(div_ready));
    endtask

    // limit grows with every issued operation.
    initial begin : watchdog
        while (cycle <= n_issued * (muldiv_pkg::DIV_CYCLES + 4) + TIMEOUT_MARGIN) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles with results still outstanding", cycle);
        for (int i = 0; i < 8; i++) begin
            if (pending[i]) begin
                $display("id %0d was never written back", i);
            end
        end
        other_errors++;
        finish_run();
    end

    initial begin
        void'($urandom(77335));
        rst       = 1'b1;
        issue     = 1'b0;
        issue_op  = muldiv_pkg::MUL;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_id  = '0;
        test_name = "reset";
        for (int i = 0; i < 8; i++) begin
            pending[i]       = 1'b0;
            expected_data[i] = '0;
            issue_cycle[i]   = 0;
            wb_latency[i]    = 0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_multiplies();
        test_divides();
        test_mixed();
        test_backpressure();
        finish_run();
    end

endmodule

//--- muldiv_wb.f
design/muldiv_pkg.sv
design/lutram_fifo.sv
design/mul_pipe.sv
design/div_iter.sv
design/wb_arbiter.sv
design/muldiv_wb.sv
dv/muldiv_wb_tb.sv
